// ==== rtl/alu_cluster_pkg.sv ====
package alu_cluster_pkg;

  localparam int XLEN_W    = 64;
  localparam int RNID_W    = 5;
  localparam int NUM_ALU   = 2;
  localparam int TAG_W     = 4;
  localparam int RETIRE_W  = 16;
  localparam int NUM_PREGS = 2 ** RNID_W;
  localparam int SHAMT_W   = $clog2(XLEN_W);
  localparam int ALU_SEL_W = $clog2(NUM_ALU);

  // rv64 major opcodes handled by the cluster.
  typedef enum logic [6:0] {
    MAJ_OP        = 7'b0110011,
    MAJ_OP_IMM    = 7'b0010011,
    MAJ_OP_32     = 7'b0111011,
    MAJ_OP_IMM_32 = 7'b0011011,
    MAJ_LUI       = 7'b0110111,
    MAJ_AUIPC     = 7'b0010111
  } major_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADD,
    OP_SUB,
    OP_ADD_32,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLL_32,
    OP_SRL_32,
    OP_SRA_32,
    OP_LUI,
    OP_AUIPC
  } op_t;

  typedef enum logic [1:0] {
    IMM_NONE, // operand 2 is rs2.
    IMM_I,
    IMM_SH,
    IMM_U
  } imm_t;

  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic [XLEN_W-1:0] pc;
    logic [RNID_W-1:0] rs1_rnid;
    logic [RNID_W-1:0] rs2_rnid;
    logic [RNID_W-1:0] rd_rnid;
    logic [TAG_W-1:0]  tag;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN_W-1:0] rd_data;
  } phy_wr_t;

endpackage

// ==== rtl/alu_cluster_if.sv ====
interface issue_if;
  import alu_cluster_pkg::*;

  issue_t issue; // valid marks ex0 of the receiving pipe.

  modport sender (output issue);
  modport receiver (input issue);

endinterface

interface done_if;
  import alu_cluster_pkg::*;

  logic              done;
  logic [TAG_W-1:0]  tag;
  logic              rd_valid;
  logic [RNID_W-1:0] rd_rnid;
  logic [XLEN_W-1:0] data;

  modport sender (
    output done, tag, rd_valid, rd_rnid, data
  );
  modport receiver (
    input done, tag, rd_valid, rd_rnid, data
  );

endinterface

// ==== rtl/issue_dispatch.sv ====
module issue_dispatch (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  alu_cluster_pkg::issue_t i_issue,
  issue_if.sender                 o_pipe [alu_cluster_pkg::NUM_ALU]
);
  import alu_cluster_pkg::*;

  logic [ALU_SEL_W-1:0] r_ptr;
  logic [NUM_ALU-1:0]   r_valid;
  issue_t               r_payload;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptr   <= '0;
      r_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_ALU; i++) begin
        r_valid[i] <= i_issue.valid && (r_ptr == ALU_SEL_W'(i));
      end
      if (i_issue.valid) begin
        r_ptr <= (r_ptr == ALU_SEL_W'(NUM_ALU - 1)) ? '0 : r_ptr + 1'b1;
      end
    end
  end

  // one payload copy feeds every pipe; only the strobe is steered.
  always_ff @(posedge i_clk) begin
    r_payload <= i_issue;
  end

  for (genvar g = 0; g < NUM_ALU; g++) begin : g_pipe_out
    always_comb begin
      o_pipe[g].issue       = r_payload;
      o_pipe[g].issue.valid = r_valid[g];
    end
  end

  a_one_pipe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(r_valid));

endmodule

// ==== rtl/alu_decode.sv ====
module alu_decode (
  input  logic [31:0]           i_inst,
  output alu_cluster_pkg::op_t  o_op,
  output alu_cluster_pkg::imm_t o_imm,
  output logic                  o_rs1_use,
  output logic                  o_rs2_use
);
  import alu_cluster_pkg::*;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [6:0] w_funct7;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_funct7 = i_inst[31:25];

  always_comb begin
    o_op      = OP_NONE;
    o_imm     = IMM_NONE;
    o_rs1_use = 1'b0;
    o_rs2_use = 1'b0;
    case (w_opcode)
      MAJ_OP: begin
        o_rs1_use = 1'b1;
        o_rs2_use = 1'b1;
        if (w_funct3 == 3'b000 && w_funct7 == 7'h00) o_op = OP_ADD;
        if (w_funct3 == 3'b000 && w_funct7 == 7'h20) o_op = OP_SUB;
        if (w_funct3 == 3'b001 && w_funct7 == 7'h00) o_op = OP_SLL;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h00) o_op = OP_SRL;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h20) o_op = OP_SRA;
      end
      MAJ_OP_IMM: begin
        o_rs1_use = 1'b1;
        o_imm     = (w_funct3 == 3'b000) ? IMM_I : IMM_SH;
        // rv64 shifts keep bit 25 for shamt[5].
        if (w_funct3 == 3'b000) o_op = OP_ADD;
        if (w_funct3 == 3'b001 && w_funct7[6:1] == 6'h00) o_op = OP_SLL;
        if (w_funct3 == 3'b101 && w_funct7[6:1] == 6'h00) o_op = OP_SRL;
        if (w_funct3 == 3'b101 && w_funct7[6:1] == 6'h10) o_op = OP_SRA;
      end
      MAJ_OP_32: begin
        o_rs1_use = 1'b1;
        o_rs2_use = 1'b1;
        if (w_funct3 == 3'b000 && w_funct7 == 7'h00) o_op = OP_ADD_32;
        if (w_funct3 == 3'b001 && w_funct7 == 7'h00) o_op = OP_SLL_32;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h00) o_op = OP_SRL_32;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h20) o_op = OP_SRA_32;
      end
      MAJ_OP_IMM_32: begin
        o_rs1_use = 1'b1;
        o_imm     = (w_funct3 == 3'b000) ? IMM_I : IMM_SH;
        if (w_funct3 == 3'b000) o_op = OP_ADD_32;
        if (w_funct3 == 3'b001 && w_funct7 == 7'h00) o_op = OP_SLL_32;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h00) o_op = OP_SRL_32;
        if (w_funct3 == 3'b101 && w_funct7 == 7'h20) o_op = OP_SRA_32;
      end
      MAJ_LUI: begin
        o_op  = OP_LUI;
        o_imm = IMM_U;
      end
      MAJ_AUIPC: begin
        o_op  = OP_AUIPC;
        o_imm = IMM_U;
      end
      default: o_op = OP_NONE; // result reads as 0.
    endcase
  end

endmodule

// ==== rtl/alu_pipe.sv ====
module alu_pipe (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  issue_if.receiver                            i_issue,
  output logic [alu_cluster_pkg::RNID_W-1:0]   o_rs1_rnid,
  output logic [alu_cluster_pkg::RNID_W-1:0]   o_rs2_rnid,
  input  logic [alu_cluster_pkg::XLEN_W-1:0]   i_rs1_data,
  input  logic [alu_cluster_pkg::XLEN_W-1:0]   i_rs2_data,
  input  alu_cluster_pkg::phy_wr_t             i_fwd [alu_cluster_pkg::NUM_ALU],
  output alu_cluster_pkg::phy_wr_t             o_ex3_phy_wr,
  done_if.sender                               o_done
);
  import alu_cluster_pkg::*;

  op_t               w_ex0_op;
  imm_t              w_ex0_imm;
  logic              w_ex0_rs1_use;
  logic              w_ex0_rs2_use;

  logic              r_ex1_valid;
  issue_t            r_ex1_issue;
  op_t               r_ex1_op;
  imm_t              r_ex1_imm;
  logic              r_ex1_rs1_use;
  logic              r_ex1_rs2_use;
  logic [XLEN_W-1:0] w_ex1_op2;

  logic              r_ex2_valid;
  issue_t            r_ex2_issue;
  op_t               r_ex2_op;
  logic              r_ex2_rs1_use;
  logic              r_ex2_rs2_use;
  logic [XLEN_W-1:0] r_ex2_rs1_data;
  logic [XLEN_W-1:0] r_ex2_rs2_data;
  logic [NUM_ALU-1:0] w_ex2_rs1_hit;
  logic [NUM_ALU-1:0] w_ex2_rs2_hit;
  logic [XLEN_W-1:0] w_ex2_rs1_fwd;
  logic [XLEN_W-1:0] w_ex2_rs2_fwd;
  logic [XLEN_W-1:0] w_ex2_op1;
  logic [XLEN_W-1:0] w_ex2_op2;
  logic [31:0]       w_ex2_word;
  logic [XLEN_W-1:0] w_ex2_result;

  logic              r_ex3_valid;
  logic [RNID_W-1:0] r_ex3_rd_rnid;
  logic [TAG_W-1:0]  r_ex3_tag;
  logic [XLEN_W-1:0] r_ex3_result;

  alu_decode u_decode (
    .i_inst    (i_issue.issue.inst),
    .o_op      (w_ex0_op),
    .o_imm     (w_ex0_imm),
    .o_rs1_use (w_ex0_rs1_use),
    .o_rs2_use (w_ex0_rs2_use)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.issue.valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  // unused sources read id 0, which the register file returns as zero.
  assign o_rs1_rnid = r_ex1_rs1_use ? r_ex1_issue.rs1_rnid : '0;
  assign o_rs2_rnid = r_ex1_rs2_use ? r_ex1_issue.rs2_rnid : '0;

  always_comb begin
    case (r_ex1_imm)
      IMM_I:   w_ex1_op2 = {{(XLEN_W-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
      IMM_SH:  w_ex1_op2 = {{(XLEN_W-6){1'b0}}, r_ex1_issue.inst[25:20]};
      IMM_U:   w_ex1_op2 = {{(XLEN_W-32){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:12], 12'h000};
      default: w_ex1_op2 = i_rs2_data;
    endcase
  end

  always_comb begin
    w_ex2_rs1_fwd = '0;
    w_ex2_rs2_fwd = '0;
    for (int j = 0; j < NUM_ALU; j++) begin
      w_ex2_rs1_hit[j] = r_ex2_rs1_use && i_fwd[j].valid &&
                         (i_fwd[j].rd_rnid == r_ex2_issue.rs1_rnid) &&
                         (r_ex2_issue.rs1_rnid != '0);
      w_ex2_rs2_hit[j] = r_ex2_rs2_use && i_fwd[j].valid &&
                         (i_fwd[j].rd_rnid == r_ex2_issue.rs2_rnid) &&
                         (r_ex2_issue.rs2_rnid != '0);
      w_ex2_rs1_fwd = w_ex2_rs1_fwd | ({XLEN_W{w_ex2_rs1_hit[j]}} & i_fwd[j].rd_data);
      w_ex2_rs2_fwd = w_ex2_rs2_fwd | ({XLEN_W{w_ex2_rs2_hit[j]}} & i_fwd[j].rd_data);
    end
  end

  assign w_ex2_op1 = (|w_ex2_rs1_hit) ? w_ex2_rs1_fwd : r_ex2_rs1_data;
  assign w_ex2_op2 = (|w_ex2_rs2_hit) ? w_ex2_rs2_fwd : r_ex2_rs2_data;

  always_comb begin
    case (r_ex2_op)
      OP_ADD_32: w_ex2_word = w_ex2_op1[31:0] + w_ex2_op2[31:0];
      OP_SLL_32: w_ex2_word = w_ex2_op1[31:0] << w_ex2_op2[4:0];
      OP_SRL_32: w_ex2_word = w_ex2_op1[31:0] >> w_ex2_op2[4:0];
      OP_SRA_32: w_ex2_word = $signed(w_ex2_op1[31:0]) >>> w_ex2_op2[4:0];
      default:   w_ex2_word = 32'h0;
    endcase
  end

  always_comb begin
    case (r_ex2_op)
      OP_ADD:   w_ex2_result = w_ex2_op1 + w_ex2_op2;
      OP_SUB:   w_ex2_result = w_ex2_op1 - w_ex2_op2;
      OP_SLL:   w_ex2_result = w_ex2_op1 << w_ex2_op2[SHAMT_W-1:0];
      OP_SRL:   w_ex2_result = w_ex2_op1 >> w_ex2_op2[SHAMT_W-1:0];
      OP_SRA:   w_ex2_result = $signed(w_ex2_op1) >>> w_ex2_op2[SHAMT_W-1:0];
      OP_ADD_32, OP_SLL_32, OP_SRL_32, OP_SRA_32:
        w_ex2_result = {{(XLEN_W-32){w_ex2_word[31]}}, w_ex2_word};
      OP_LUI:   w_ex2_result = w_ex2_op2;
      OP_AUIPC: w_ex2_result = r_ex2_issue.pc + w_ex2_op2;
      default:  w_ex2_result = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    r_ex1_issue    <= i_issue.issue;
    r_ex1_op       <= w_ex0_op;
    r_ex1_imm      <= w_ex0_imm;
    r_ex1_rs1_use  <= w_ex0_rs1_use;
    r_ex1_rs2_use  <= w_ex0_rs2_use;
    r_ex2_issue    <= r_ex1_issue;
    r_ex2_op       <= r_ex1_op;
    r_ex2_rs1_use  <= r_ex1_rs1_use;
    r_ex2_rs2_use  <= r_ex1_rs2_use;
    r_ex2_rs1_data <= i_rs1_data;
    r_ex2_rs2_data <= w_ex1_op2;
    r_ex3_rd_rnid  <= r_ex2_issue.rd_rnid;
    r_ex3_tag      <= r_ex2_issue.tag;
    r_ex3_result   <= w_ex2_result;
  end

  assign o_ex3_phy_wr.valid   = r_ex3_valid && (r_ex3_rd_rnid != '0);
  assign o_ex3_phy_wr.rd_rnid = r_ex3_rd_rnid;
  assign o_ex3_phy_wr.rd_data = r_ex3_result;

  assign o_done.done     = r_ex3_valid;
  assign o_done.tag      = r_ex3_tag;
  assign o_done.rd_valid = r_ex3_rd_rnid != '0;
  assign o_done.rd_rnid  = r_ex3_rd_rnid;
  assign o_done.data     = r_ex3_result;

  // only one pipe can sit in ex3 at a time, so forwarding never sees two hits.
  a_fwd_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex2_valid |-> ($onehot0(w_ex2_rs1_hit) && $onehot0(w_ex2_rs2_hit)));

endmodule

// ==== rtl/phys_regfile.sv ====
module phys_regfile (
  input  logic                               i_clk,
  input  logic                               i_reset_n,
  input  alu_cluster_pkg::phy_wr_t           i_wr [alu_cluster_pkg::NUM_ALU],
  input  logic [alu_cluster_pkg::RNID_W-1:0] i_rd_rnid [2*alu_cluster_pkg::NUM_ALU],
  output logic [alu_cluster_pkg::XLEN_W-1:0] o_rd_data [2*alu_cluster_pkg::NUM_ALU]
);
  import alu_cluster_pkg::*;

  logic [XLEN_W-1:0] r_regs [NUM_PREGS];
  logic              w_wr_conflict;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < NUM_PREGS; r++) begin
        r_regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_ALU; w++) begin
        if (i_wr[w].valid) begin
          r_regs[i_wr[w].rd_rnid] <= i_wr[w].rd_data;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2 * NUM_ALU; p++) begin
      o_rd_data[p] = r_regs[i_rd_rnid[p]];
      for (int w = 0; w < NUM_ALU; w++) begin
        if (i_wr[w].valid && (i_wr[w].rd_rnid == i_rd_rnid[p])) begin
          o_rd_data[p] = i_wr[w].rd_data; // write-through.
        end
      end
      if (i_rd_rnid[p] == '0) begin
        o_rd_data[p] = '0;
      end
    end
  end

  always_comb begin
    w_wr_conflict = 1'b0;
    for (int a = 0; a < NUM_ALU; a++) begin
      for (int b = a + 1; b < NUM_ALU; b++) begin
        if (i_wr[a].valid && i_wr[b].valid && (i_wr[a].rd_rnid == i_wr[b].rd_rnid)) begin
          w_wr_conflict = 1'b1;
        end
      end
    end
  end

  a_no_dup_write: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !w_wr_conflict);

endmodule

// ==== rtl/completion_merge.sv ====
module completion_merge (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  done_if.receiver                             i_done [alu_cluster_pkg::NUM_ALU],
  output logic                                 o_done_valid,
  output logic [alu_cluster_pkg::TAG_W-1:0]    o_done_tag,
  output logic                                 o_done_rd_valid,
  output logic [alu_cluster_pkg::RNID_W-1:0]   o_done_rd_rnid,
  output logic [alu_cluster_pkg::XLEN_W-1:0]   o_done_data,
  output logic [alu_cluster_pkg::RETIRE_W-1:0] o_retire_count
);
  import alu_cluster_pkg::*;

  logic [NUM_ALU-1:0] w_done;
  logic [TAG_W-1:0]   w_tag_in [NUM_ALU];
  logic               w_rd_valid_in [NUM_ALU];
  logic [RNID_W-1:0]  w_rd_rnid_in [NUM_ALU];
  logic [XLEN_W-1:0]  w_data_in [NUM_ALU];
  logic [TAG_W-1:0]   w_tag;
  logic               w_rd_valid;
  logic [RNID_W-1:0]  w_rd_rnid;
  logic [XLEN_W-1:0]  w_data;

  for (genvar g = 0; g < NUM_ALU; g++) begin : g_unpack
    assign w_done[g]        = i_done[g].done;
    assign w_tag_in[g]      = i_done[g].tag;
    assign w_rd_valid_in[g] = i_done[g].rd_valid;
    assign w_rd_rnid_in[g]  = i_done[g].rd_rnid;
    assign w_data_in[g]     = i_done[g].data;
  end

  always_comb begin
    w_tag      = '0;
    w_rd_valid = 1'b0;
    w_rd_rnid  = '0;
    w_data     = '0;
    for (int i = 0; i < NUM_ALU; i++) begin
      w_tag      = w_tag | ({TAG_W{w_done[i]}} & w_tag_in[i]);
      w_rd_valid = w_rd_valid | (w_done[i] & w_rd_valid_in[i]);
      w_rd_rnid  = w_rd_rnid | ({RNID_W{w_done[i]}} & w_rd_rnid_in[i]);
      w_data     = w_data | ({XLEN_W{w_done[i]}} & w_data_in[i]);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done_valid   <= 1'b0;
      o_retire_count <= '0;
    end else begin
      o_done_valid <= |w_done;
      if (|w_done) begin
        o_retire_count <= o_retire_count + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    o_done_tag      <= w_tag;
    o_done_rd_valid <= w_rd_valid;
    o_done_rd_rnid  <= w_rd_rnid;
    o_done_data     <= w_data;
  end

  a_done_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_done));

endmodule

// ==== rtl/alu_cluster.sv ====
module alu_cluster (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic                                 i_issue_valid,
  input  logic [31:0]                          i_issue_inst,
  input  logic [alu_cluster_pkg::XLEN_W-1:0]   i_issue_pc,
  input  logic [alu_cluster_pkg::RNID_W-1:0]   i_issue_rs1_rnid,
  input  logic [alu_cluster_pkg::RNID_W-1:0]   i_issue_rs2_rnid,
  input  logic [alu_cluster_pkg::RNID_W-1:0]   i_issue_rd_rnid,
  input  logic [alu_cluster_pkg::TAG_W-1:0]    i_issue_tag,
  output logic                                 o_done_valid,
  output logic [alu_cluster_pkg::TAG_W-1:0]    o_done_tag,
  output logic                                 o_done_rd_valid,
  output logic [alu_cluster_pkg::RNID_W-1:0]   o_done_rd_rnid,
  output logic [alu_cluster_pkg::XLEN_W-1:0]   o_done_data,
  output logic [alu_cluster_pkg::RETIRE_W-1:0] o_retire_count
);
  import alu_cluster_pkg::*;

  issue_t            w_issue;
  phy_wr_t           w_phy_wr [NUM_ALU]; // ex3 write bus, also the forwarding source.
  logic [RNID_W-1:0] w_rd_rnid [2*NUM_ALU];
  logic [XLEN_W-1:0] w_rd_data [2*NUM_ALU];

  issue_if u_issue_if [NUM_ALU] ();
  done_if  u_done_if [NUM_ALU] ();

  assign w_issue = '{
    valid:    i_issue_valid,
    inst:     i_issue_inst,
    pc:       i_issue_pc,
    rs1_rnid: i_issue_rs1_rnid,
    rs2_rnid: i_issue_rs2_rnid,
    rd_rnid:  i_issue_rd_rnid,
    tag:      i_issue_tag
  };

  issue_dispatch u_dispatch (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (w_issue),
    .o_pipe    (u_issue_if)
  );

  for (genvar g = 0; g < NUM_ALU; g++) begin : g_pipe
    alu_pipe u_alu_pipe (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_issue      (u_issue_if[g]),
      .o_rs1_rnid   (w_rd_rnid[2*g]),
      .o_rs2_rnid   (w_rd_rnid[2*g+1]),
      .i_rs1_data   (w_rd_data[2*g]),
      .i_rs2_data   (w_rd_data[2*g+1]),
      .i_fwd        (w_phy_wr),
      .o_ex3_phy_wr (w_phy_wr[g]),
      .o_done       (u_done_if[g])
    );
  end

  phys_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr      (w_phy_wr),
    .i_rd_rnid (w_rd_rnid),
    .o_rd_data (w_rd_data)
  );

  completion_merge u_merge (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_done          (u_done_if),
    .o_done_valid    (o_done_valid),
    .o_done_tag      (o_done_tag),
    .o_done_rd_valid (o_done_rd_valid),
    .o_done_rd_rnid  (o_done_rd_rnid),
    .o_done_data     (o_done_data),
    .o_retire_count  (o_retire_count)
  );

endmodule

// ==== verification/tb_alu_cluster.sv ====
module tb_alu_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_cluster_pkg::*;

  localparam int          LATENCY = 5;
  localparam logic [63:0] PC_BASE = 64'hffff_ffc0_0010_0000;

  logic        i_clk;
  logic        i_reset_n;
  logic        i_issue_valid;
  logic [31:0] i_issue_inst;
  logic [63:0] i_issue_pc;
  logic [4:0]  i_issue_rs1_rnid;
  logic [4:0]  i_issue_rs2_rnid;
  logic [4:0]  i_issue_rd_rnid;
  logic [3:0]  i_issue_tag;
  logic        o_done_valid;
  logic [3:0]  o_done_tag;
  logic        o_done_rd_valid;
  logic [4:0]  o_done_rd_rnid;
  logic [63:0] o_done_data;
  logic [15:0] o_retire_count;

  // stimulus table, one entry per instruction.
  string       row_name[$];
  logic [31:0] row_inst[$];
  logic [63:0] row_pc[$];
  logic [4:0]  row_rs1[$];
  logic [4:0]  row_rs2[$];
  logic [4:0]  row_rd[$];
  logic [3:0]  row_tag[$];
  int          row_gap[$];
  logic [63:0] row_exp[$];

  int          exp_row[$]; // scoreboard, in issue order.
  int          exp_due[$];
  logic [63:0] model[32];
  logic [31:0] lcg_state;
  int          max_gap;
  int          cyc;
  bit          table_ready;

  alu_cluster UUT (.*);

  initial begin
    i_clk = 1'b0;
    cyc   = 0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [19:0] rand_upper();
    logic [31:0] v;
    v = lcg_next();
    return v[31:12];
  endfunction

  function automatic logic [19:0] rand_imm12();
    logic [31:0] v;
    v = lcg_next();
    return {8'h00, v[31:20]};
  endfunction

  // rv64 encodings; shift immediates carry shamt in imm[5:0].
  function automatic logic [31:0] encode(op_t op, bit use_imm, logic [4:0] rd,
                                         logic [4:0] rs1, logic [4:0] rs2, logic [19:0] imm);
    logic [31:0] r_form;
    logic [31:0] i_form;
    r_form = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
    i_form = {imm[11:0], rs1, 3'b000, rd, 7'h13};
    case (op)
      OP_ADD:    return use_imm ? i_form : r_form;
      OP_SUB:    return {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
      OP_SLL:    return use_imm ? {6'h00, imm[5:0], rs1, 3'b001, rd, 7'h13}
                                : {7'h00, rs2, rs1, 3'b001, rd, 7'h33};
      OP_SRL:    return use_imm ? {6'h00, imm[5:0], rs1, 3'b101, rd, 7'h13}
                                : {7'h00, rs2, rs1, 3'b101, rd, 7'h33};
      OP_SRA:    return use_imm ? {6'h10, imm[5:0], rs1, 3'b101, rd, 7'h13}
                                : {7'h20, rs2, rs1, 3'b101, rd, 7'h33};
      OP_ADD_32: return use_imm ? {imm[11:0], rs1, 3'b000, rd, 7'h1b}
                                : {7'h00, rs2, rs1, 3'b000, rd, 7'h3b};
      OP_SLL_32: return use_imm ? {7'h00, imm[4:0], rs1, 3'b001, rd, 7'h1b}
                                : {7'h00, rs2, rs1, 3'b001, rd, 7'h3b};
      OP_SRL_32: return use_imm ? {7'h00, imm[4:0], rs1, 3'b101, rd, 7'h1b}
                                : {7'h00, rs2, rs1, 3'b101, rd, 7'h3b};
      OP_SRA_32: return use_imm ? {7'h20, imm[4:0], rs1, 3'b101, rd, 7'h1b}
                                : {7'h20, rs2, rs1, 3'b101, rd, 7'h3b};
      OP_LUI:    return {imm, rd, 7'h37};
      OP_AUIPC:  return {imm, rd, 7'h17};
      default:   return 32'h0000_0073; // ecall, not an alu op.
    endcase
  endfunction

  function automatic logic [63:0] expected_result(op_t op, logic [63:0] a, logic [63:0] b,
                                                  logic [19:0] imm, logic [63:0] pc);
    logic [31:0] w;
    logic [63:0] u;
    u = {{32{imm[19]}}, imm, 12'h000};
    case (op)
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_SLL:    return a << b[5:0];
      OP_SRL:    return a >> b[5:0];
      OP_SRA:    return $signed(a) >>> b[5:0];
      OP_ADD_32: w = a[31:0] + b[31:0];
      OP_SLL_32: w = a[31:0] << b[4:0];
      OP_SRL_32: w = a[31:0] >> b[4:0];
      OP_SRA_32: w = $signed(a[31:0]) >>> b[4:0];
      OP_LUI:    return u;
      OP_AUIPC:  return pc + u;
      default:   return 64'd0;
    endcase
    return {{32{w[31]}}, w}; // word ops sign-extend bit 31.
  endfunction

  function automatic void add_row(string name, op_t op, bit use_imm, int rd, int rs1,
                                  int rs2, logic [19:0] imm, int gap);
    int          idx;
    logic [63:0] pc;
    logic [63:0] b;
    logic [63:0] res;
    idx = row_name.size();
    pc  = PC_BASE + 64'(idx * 4);
    if (!use_imm) begin
      b = model[rs2];
    end else if (op == OP_ADD || op == OP_ADD_32) begin
      b = {{52{imm[11]}}, imm[11:0]};
    end else begin
      b = {58'd0, imm[5:0]};
    end
    res = expected_result(op, model[rs1], b, imm, pc);
    if (rd != 0) begin
      model[rd] = res;
    end
    row_name.push_back(name);
    row_inst.push_back(encode(op, use_imm, 5'(rd), 5'(rs1), 5'(rs2), imm));
    row_pc.push_back(pc);
    row_rs1.push_back(5'(rs1));
    row_rs2.push_back(5'(rs2));
    row_rd.push_back(5'(rd));
    row_tag.push_back(4'(idx));
    row_gap.push_back(gap);
    row_exp.push_back(res);
    if (gap > max_gap) begin
      max_gap = gap;
    end
  endfunction

  // gap counts idle cycles before the row; 0 means back-to-back.
  task automatic build_table();
    lcg_state = 32'hf800_05e4;
    max_gap   = 0;
    for (int r = 0; r < 32; r++) begin
      model[r] = 64'd0;
    end
    add_row("lui_x1", OP_LUI, 1'b0, 1, 0, 0, rand_upper(), 0);
    add_row("addi_x1_fwd", OP_ADD, 1'b1, 1, 1, 0, rand_imm12(), 0);
    add_row("lui_x2", OP_LUI, 1'b0, 2, 0, 0, rand_upper(), 0);
    add_row("addi_x2_wthru", OP_ADD, 1'b1, 2, 2, 0, rand_imm12(), 1);
    add_row("add_x3", OP_ADD, 1'b0, 3, 1, 2, 20'h0, 0);
    add_row("sub_x4_rf", OP_SUB, 1'b0, 4, 3, 1, 20'h0, 2);
    add_row("sll_x5_gap3", OP_SLL, 1'b0, 5, 4, 2, 20'h0, 3);
    add_row("srl_x6", OP_SRL, 1'b0, 6, 4, 2, 20'h0, 0);
    add_row("sra_x7", OP_SRA, 1'b0, 7, 5, 1, 20'h0, 0);
    add_row("lui_neg_x11", OP_LUI, 1'b0, 11, 0, 0, 20'h80001, 0);
    add_row("addi_x11", OP_ADD, 1'b1, 11, 11, 0, rand_imm12(), 0);
    add_row("slli_x8", OP_SLL, 1'b1, 8, 4, 0, 20'd37, 1);
    add_row("srli_x9", OP_SRL, 1'b1, 9, 11, 0, 20'd45, 0);
    add_row("srai_x10", OP_SRA, 1'b1, 10, 11, 0, 20'd13, 0);
    add_row("addw_x12", OP_ADD_32, 1'b0, 12, 1, 2, 20'h0, 0);
    add_row("addiw_x13", OP_ADD_32, 1'b1, 13, 11, 0, 20'hfffff, 2);
    add_row("sllw_x14", OP_SLL_32, 1'b0, 14, 2, 1, 20'h0, 0);
    add_row("srlw_x15", OP_SRL_32, 1'b0, 15, 11, 2, 20'h0, 1);
    add_row("sraw_x16", OP_SRA_32, 1'b0, 16, 11, 1, 20'h0, 0);
    add_row("slliw_x17", OP_SLL_32, 1'b1, 17, 1, 0, 20'd31, 0);
    add_row("srliw_x18", OP_SRL_32, 1'b1, 18, 11, 0, 20'd4, 3);
    add_row("sraiw_x19", OP_SRA_32, 1'b1, 19, 11, 0, 20'd7, 0);
    add_row("auipc_x20", OP_AUIPC, 1'b0, 20, 0, 0, rand_upper(), 0);
    add_row("add_x21_auipc", OP_ADD, 1'b0, 21, 20, 3, 20'h0, 0);
    add_row("lui_x0", OP_LUI, 1'b0, 0, 0, 0, rand_upper(), 0);
    add_row("add_x22_x0_fwd", OP_ADD, 1'b0, 22, 0, 1, 20'h0, 0);
    add_row("add_x23_x0_rf", OP_ADD, 1'b0, 23, 0, 2, 20'h0, 2);
    add_row("unknown_x24", OP_NONE, 1'b0, 24, 0, 0, 20'h0, 0);
    add_row("add_x25_x24", OP_ADD, 1'b0, 25, 24, 1, 20'h0, 0);
    for (int k = 0; k < 4; k++) begin
      add_row($sformatf("addi_chain_%0d", k), OP_ADD, 1'b1, 26, 26, 0, rand_imm12(), 0);
    end
    add_row("sub_x27_chain", OP_SUB, 1'b0, 27, 26, 3, 20'h0, 1);
  endtask

  task automatic idle_cycle();
    @(posedge i_clk);
    #1;
    i_issue_valid = 1'b0;
  endtask

  task automatic issue_row(int i);
    @(posedge i_clk);
    #1;
    i_issue_valid    = 1'b1;
    i_issue_inst     = row_inst[i];
    i_issue_pc       = row_pc[i];
    i_issue_rs1_rnid = row_rs1[i];
    i_issue_rs2_rnid = row_rs2[i];
    i_issue_rd_rnid  = row_rd[i];
    i_issue_tag      = row_tag[i];
    exp_row.push_back(i);
    exp_due.push_back(cyc + LATENCY);
  endtask

  // outputs are registered, so the falling edge sees them settled.
  always @(negedge i_clk) begin : monitor
    int r;
    int due;
    if (i_reset_n && o_done_valid) begin
      if (exp_row.size() == 0) begin
        fail_run("a done strobe arrived with no instruction outstanding");
      end else begin
        r   = exp_row.pop_front();
        due = exp_due.pop_front();
        check({row_name[r], " tag"}, 64'(row_tag[r]), 64'(o_done_tag));
        check({row_name[r], " data"}, row_exp[r], o_done_data);
        check({row_name[r], " rd_rnid"}, 64'(row_rd[r]), 64'(o_done_rd_rnid));
        check({row_name[r], " rd_valid"}, 64'(row_rd[r] != '0), 64'(o_done_rd_valid));
        check({row_name[r], " latency"}, 64'(due), 64'(cyc));
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = row_name.size() * (max_gap + LATENCY) + 100;
    repeat (limit) @(posedge i_clk);
    fail_run("watchdog expired before every instruction completed");
  end

  initial begin : stimulus
    i_reset_n        = 1'b0;
    i_issue_valid    = 1'b0;
    i_issue_inst     = 32'h0;
    i_issue_pc       = 64'h0;
    i_issue_rs1_rnid = 5'h0;
    i_issue_rs2_rnid = 5'h0;
    i_issue_rd_rnid  = 5'h0;
    i_issue_tag      = 4'h0;
    table_ready      = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    check("reset done_valid", 64'd0, 64'(o_done_valid));
    check("reset retire_count", 64'd0, 64'(o_retire_count));
    for (int i = 0; i < row_name.size(); i++) begin
      repeat (row_gap[i]) idle_cycle();
      issue_row(i);
    end
    idle_cycle();
    while (exp_row.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    check("final retire_count", 64'(row_name.size()), 64'(o_retire_count));
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== alu_cluster.f ====
rtl/alu_cluster_pkg.sv
rtl/alu_cluster_if.sv
rtl/issue_dispatch.sv
rtl/alu_decode.sv
rtl/alu_pipe.sv
rtl/phys_regfile.sv
rtl/completion_merge.sv
rtl/alu_cluster.sv
verification/tb_alu_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the alu_cluster testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_alu_cluster -Mdir obj_dir -f alu_cluster.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_alu_cluster
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit $status
